// ==== design/flash_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// shared types for the serial flash read path
// opcodes, reader phases and the bundles that cross module
// boundaries; RTL and testbench both import this package
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package flash_pkg;

    // read opcodes understood by the flash
    typedef enum logic [7:0] {
        CMD_READ      = 8'h03,
        CMD_QUAD_READ = 8'heb
    } flash_cmd_e;

    // reader phases, each names the step loaded once the current transfer ends
    typedef enum logic [3:0] {
        ST_CMD,
        ST_ADDR_HI,
        ST_ADDR_MID,
        ST_ADDR_LO,
        ST_MODE,
        ST_DATA_FIRST,
        ST_DATA,
        ST_WORD_DONE,
        ST_HOLD
    } reader_state_e;

    // pins driven toward the flash
    typedef struct packed {
        logic       csn;
        logic       sclk;
        logic [3:0] io_out;
        logic [3:0] io_oe;
    } flash_pins_t;

    // requester side, byte address with the low two bits zero
    typedef struct packed {
        logic [23:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } fetch_rsp_t;

    // M5:4 = 10b keeps the flash in continuous read
    localparam logic [7:0] MODE_BITS_CRM = 8'h20;

endpackage

`default_nettype wire

// ==== design/flash_reader.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// read sequencer for a serial NOR flash
// sends command, address, mode and dummy clocks, then streams
// little-endian words out with a one-cycle rd_ready pulse each,
// parking sclk high at a word boundary while rd_hold is set
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module flash_reader #(
    parameter bit qspi_mode = 1'b1,
    parameter bit use_crm   = 1'b1
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    rd_valid,
    input  wire                    rd_continue,
    input  wire                    rd_hold,
    input  wire  [23:0]            rd_addr,
    output logic                   rd_ready,
    output logic [31:0]            rd_data,

    output flash_pkg::flash_pins_t pins,
    input  wire  [3:0]             io_in
);
    import flash_pkg::*;

    // clocks per byte outside the command phase
    localparam logic [3:0] io_cycles = qspi_mode ? 4'd2 : 4'd8;
    localparam flash_cmd_e read_cmd  = qspi_mode ? CMD_QUAD_READ : CMD_READ;
    localparam bit         crm_en    = qspi_mode && use_crm;

    reader_state_e state;
    reader_state_e start_state;

    logic [7:0]  buffer;
    logic [3:0]  xfer_cnt;
    logic [3:0]  oe_count;
    logic [1:0]  byte_cnt;
    logic [23:0] word_lo;
    logic        cmd_phase;
    logic        crm_active;

    logic        wide;
    logic        oe_on;
    logic        end_xfer;

    // the command always goes out on io0, even in a quad build
    assign wide  = qspi_mode && !cmd_phase;
    assign oe_on = (oe_count != 4'd0);

    // flash already in continuous read, so skip the opcode
    assign start_state = crm_active ? ST_ADDR_HI : ST_CMD;

    // dropping rd_valid, or a word with no continuation, closes the transaction
    assign end_xfer = !rd_valid || (rd_ready && !rd_continue);

    always_ff @(posedge clk) begin
        rd_ready <= 1'b0;
        if (!rst_n) begin
            pins.csn    <= 1'b1;
            pins.sclk   <= 1'b1;
            pins.io_out <= 4'b0000;
            pins.io_oe  <= 4'b0000;
            state       <= ST_CMD;
            xfer_cnt    <= 4'd0;
            oe_count    <= 4'd0;
            byte_cnt    <= 2'd0;
            cmd_phase   <= 1'b0;
            crm_active  <= 1'b0;
        end else if (end_xfer) begin
            pins.csn    <= 1'b1;
            pins.sclk   <= 1'b1;
            pins.io_out <= 4'b0000;
            pins.io_oe  <= 4'b0000;
            state       <= start_state;
            xfer_cnt    <= 4'd0;
            oe_count    <= 4'd0;
            byte_cnt    <= 2'd0;
            cmd_phase   <= 1'b0;
        end else begin
            pins.csn <= 1'b0;

            if (xfer_cnt != 4'd0) begin
                if (pins.sclk) begin
                    // falling sclk, put the next bits on the bus
                    pins.sclk   <= 1'b0;
                    pins.io_out <= wide ? buffer[7:4] : {3'b000, buffer[7]};
                    pins.io_oe  <= wide ? {4{oe_on}} : {3'b000, oe_on};
                    if (oe_on) begin
                        oe_count <= oe_count - 4'd1;
                    end
                end else begin
                    // rising sclk, both sides sample here
                    pins.sclk <= 1'b1;
                    buffer    <= wide ? {buffer[3:0], io_in} : {buffer[6:0], io_in[1]};
                    xfer_cnt  <= xfer_cnt - 4'd1;
                end
            end else begin
                case (state)
                    ST_CMD: begin
                        buffer    <= read_cmd;
                        xfer_cnt  <= 4'd8;
                        oe_count  <= 4'd8;
                        cmd_phase <= 1'b1;
                        state     <= ST_ADDR_HI;
                    end
                    ST_ADDR_HI: begin
                        buffer    <= rd_addr[23:16];
                        xfer_cnt  <= io_cycles;
                        oe_count  <= io_cycles;
                        cmd_phase <= 1'b0;
                        state     <= ST_ADDR_MID;
                    end
                    ST_ADDR_MID: begin
                        buffer   <= rd_addr[15:8];
                        xfer_cnt <= io_cycles;
                        oe_count <= io_cycles;
                        state    <= ST_ADDR_LO;
                    end
                    ST_ADDR_LO: begin
                        buffer   <= rd_addr[7:0];
                        xfer_cnt <= io_cycles;
                        oe_count <= io_cycles;
                        state    <= qspi_mode ? ST_MODE : ST_DATA_FIRST;
                    end
                    ST_MODE: begin
                        // two mode clocks then four dummy clocks in one transfer;
                        // only the upper mode nibble is driven so the bus can turn
                        buffer   <= use_crm ? MODE_BITS_CRM : 8'h00;
                        xfer_cnt <= 4'd6;
                        oe_count <= 4'd1;
                        state    <= ST_DATA_FIRST;
                    end
                    ST_DATA_FIRST: begin
                        // mode bits have gone out completely by now
                        if (crm_en) begin
                            crm_active <= 1'b1;
                        end
                        xfer_cnt <= io_cycles;
                        oe_count <= 4'd0;
                        byte_cnt <= 2'd0;
                        state    <= ST_DATA;
                    end
                    ST_DATA: begin
                        // first byte lands in the low lane
                        word_lo[8*byte_cnt +: 8] <= buffer;
                        byte_cnt <= byte_cnt + 2'd1;
                        xfer_cnt <= io_cycles;
                        if (byte_cnt == 2'd2) begin
                            state <= ST_WORD_DONE;
                        end
                    end
                    ST_WORD_DONE: begin
                        rd_data  <= {buffer, word_lo};
                        rd_ready <= 1'b1;
                        state    <= ST_HOLD;
                    end
                    ST_HOLD: begin
                        // sclk stays high here, the flash just waits;
                        // rd_hold only covers the new word after the rd_ready cycle
                        if (!rd_hold && !rd_ready) begin
                            xfer_cnt <= io_cycles;
                            byte_cnt <= 2'd0;
                            state    <= ST_DATA;
                        end
                    end
                    default: begin
                        state <= start_state;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// four-phase requester port in front of the flash reader
// tracks the next sequential address, keeps one prefetched word
// and restarts the flash stream when the address jumps
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fetch_port (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire                     req,
    input  wire flash_pkg::fetch_req_t req_data,
    output logic                    ack,
    output flash_pkg::fetch_rsp_t   rsp,

    output logic                    rd_valid,
    output logic                    rd_continue,
    output logic                    rd_hold,
    output logic [23:0]             rd_addr,
    input  wire                     rd_ready,
    input  wire  [31:0]             rd_data
);
    typedef enum logic [1:0] {
        P_IDLE,
        P_RESTART,
        P_WAIT,
        P_ACK
    } port_state_e;

    port_state_e state;

    logic [23:0] next_addr;
    logic [31:0] buf_data;
    logic        buf_full;

    logic        new_req;
    logic        seq_hit;
    logic        take_buf;
    logic        take_rd;
    logic        restart;
    logic        to_buf;

    // only a request seen with ack low is a new one
    assign new_req = (state == P_IDLE) && req;
    assign seq_hit = rd_valid && (req_data.addr == next_addr);

    assign take_buf = new_req && seq_hit && buf_full;
    assign take_rd  = (new_req && seq_hit && !buf_full && rd_ready)
                   || ((state == P_WAIT) && rd_ready);
    assign restart  = new_req && !seq_hit;

    // a word nobody is waiting for becomes the prefetch
    assign to_buf = rd_ready && rd_valid && !take_rd && !restart;

    assign rd_continue = rd_valid;
    assign rd_hold     = buf_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= P_IDLE;
            ack      <= 1'b0;
            rd_valid <= 1'b0;
            buf_full <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (restart) begin
                        // one low cycle makes the reader close the stream
                        rd_valid <= 1'b0;
                        state    <= P_RESTART;
                    end else if (take_buf || take_rd) begin
                        ack   <= 1'b1;
                        state <= P_ACK;
                    end else if (req) begin
                        state <= P_WAIT;
                    end
                end
                P_RESTART: begin
                    rd_valid <= 1'b1;
                    state    <= P_WAIT;
                end
                P_WAIT: begin
                    if (take_rd) begin
                        ack   <= 1'b1;
                        state <= P_ACK;
                    end
                end
                P_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= P_IDLE;
                    end
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase

            if (restart || take_buf) begin
                buf_full <= 1'b0;
            end else if (to_buf) begin
                buf_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_buf) begin
            rsp.rdata <= buf_data;
        end else if (take_rd) begin
            rsp.rdata <= rd_data;
        end

        if (to_buf) begin
            buf_data <= rd_data;
        end

        if (take_buf || take_rd) begin
            next_addr <= next_addr + 24'd4;
        end else if (restart) begin
            next_addr <= req_data.addr;
            rd_addr   <= req_data.addr;
        end
    end

endmodule

`default_nettype wire

// ==== design/flash_subsys.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// flash read subsystem top level
// requester port plus flash reader; qspi_mode and use_crm
// pick the bus width and continuous read at build time
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module flash_subsys #(
    parameter bit qspi_mode = 1'b1,
    parameter bit use_crm   = 1'b1
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req,
    input  wire flash_pkg::fetch_req_t req_data,
    output flash_pkg::fetch_rsp_t      rsp,
    output logic                       ack,
    output flash_pkg::flash_pins_t     flash_pins,
    input  wire  [3:0]                 flash_io_in
);
    // reader handshake
    logic        rd_valid;
    logic        rd_continue;
    logic        rd_hold;
    logic        rd_ready;
    logic [23:0] rd_addr;
    logic [31:0] rd_data;

    fetch_port u_fetch_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_data    (req_data),
        .ack         (ack),
        .rsp         (rsp),
        .rd_valid    (rd_valid),
        .rd_continue (rd_continue),
        .rd_hold     (rd_hold),
        .rd_addr     (rd_addr),
        .rd_ready    (rd_ready),
        .rd_data     (rd_data)
    );

    flash_reader #(
        .qspi_mode (qspi_mode),
        .use_crm   (use_crm)
    ) u_flash_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_valid    (rd_valid),
        .rd_continue (rd_continue),
        .rd_hold     (rd_hold),
        .rd_addr     (rd_addr),
        .rd_ready    (rd_ready),
        .rd_data     (rd_data),
        .pins        (flash_pins),
        .io_in       (flash_io_in)
    );

endmodule

`default_nettype wire

// ==== sim/spi_flash_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// behavioral serial NOR flash for simulation
// answers 03h and EBh reads, tracks continuous read mode
// and counts command and mode bytes for the testbench
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model #(
    parameter bit qspi = 1'b1
) (
    input  wire flash_pkg::flash_pins_t pins,
    output logic [3:0]                  io_in
);
    import flash_pkg::*;

    typedef enum logic [2:0] {
        PH_CMD,
        PH_ADDR,
        PH_MODE,
        PH_DUMMY,
        PH_DATA
    } phase_e;

    wire       sclk;
    wire       csn;
    wire [3:0] io;

    assign sclk = pins.sclk;
    assign csn  = pins.csn;
    assign io   = pins.io_out;

    phase_e      phase;
    logic        crm;
    logic [23:0] sr;
    logic [23:0] addr;
    int          cnt;
    int          dcnt;

    // read by the testbench
    int          cmd_count;
    int          quad_cmd_count;
    int          addr_count;
    int          mode_count;

    // content of the array at byte address a
    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        logic [31:0] prod;
        prod = a * 32'h9d + 32'h5b;
        return prod[7:0] ^ a[23:16];
    endfunction

    initial begin
        io_in          <= 4'h0;
        phase          = PH_CMD;
        crm            = 1'b0;
        sr             = 24'h0;
        addr           = 24'h0;
        cnt            = 0;
        dcnt           = 0;
        cmd_count      = 0;
        quad_cmd_count = 0;
        addr_count     = 0;
        mode_count     = 0;
    end

    // rising sclk, take in command, address and mode bits
    always @(posedge sclk or posedge csn) begin
        if (csn !== 1'b0) begin
            phase = (qspi && crm) ? PH_ADDR : PH_CMD;
            cnt   = 0;
            sr    = 24'h0;
        end else begin
            case (phase)
                PH_CMD: begin
                    sr  = {sr[22:0], io[0]};
                    cnt = cnt + 1;
                    if (cnt == 8) begin
                        cmd_count = cmd_count + 1;
                        if (sr[7:0] == CMD_QUAD_READ) begin
                            quad_cmd_count = quad_cmd_count + 1;
                        end
                        phase = PH_ADDR;
                        cnt   = 0;
                        sr    = 24'h0;
                    end
                end
                PH_ADDR: begin
                    sr  = qspi ? {sr[19:0], io} : {sr[22:0], io[0]};
                    cnt = cnt + 1;
                    if (cnt == (qspi ? 6 : 24)) begin
                        addr       = sr;
                        addr_count = addr_count + 1;
                        phase      = qspi ? PH_MODE : PH_DATA;
                        cnt        = 0;
                        sr         = 24'h0;
                    end
                end
                PH_MODE: begin
                    sr  = {sr[19:0], io};
                    cnt = cnt + 1;
                    if (cnt == 2) begin
                        // only M7:4 matters, 2h keeps continuous read
                        crm = (sr[7:4] == MODE_BITS_CRM[7:4]);
                        if (crm) begin
                            mode_count = mode_count + 1;
                        end
                        phase = PH_DUMMY;
                        cnt   = 0;
                    end
                end
                PH_DUMMY: begin
                    cnt = cnt + 1;
                    if (cnt == 4) begin
                        phase = PH_DATA;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // falling sclk, data out, high nibble or msb first
    always @(negedge sclk) begin
        logic [7:0] b;
        if (csn === 1'b0 && phase == PH_DATA) begin
            if (qspi) begin
                b = flash_byte(addr + 24'(dcnt / 2));
                io_in <= dcnt[0] ? b[3:0] : b[7:4];
            end else begin
                b = flash_byte(addr + 24'(dcnt / 8));
                io_in <= {2'b00, b[7 - dcnt % 8], 1'b0};
            end
            dcnt = dcnt + 1;
        end else begin
            dcnt = 0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_flash_subsys.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the flash read subsystem
// random sequential and jumping reads against a flash model,
// tb_qspi selects the quad or single-line build
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_flash_subsys #(
    parameter bit tb_qspi = 1'b1
);
    import flash_pkg::*;

    localparam int ack_timeout = 5000;

    logic        clk;
    logic        rst_n;
    logic        req;
    fetch_req_t  req_data;
    fetch_rsp_t  rsp;
    logic        ack;
    flash_pins_t flash_pins;
    logic [3:0]  flash_io_in;

    integer      seed;
    int          errors;
    int          checks;
    bit          hung;
    int          csn_high_cycles = 0;

    // counts seen when the last request completed
    int          csn_mark = 0;
    int          cmd_mark = 0;

    flash_subsys #(
        .qspi_mode (tb_qspi),
        .use_crm   (1'b1)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_data    (req_data),
        .rsp         (rsp),
        .ack         (ack),
        .flash_pins  (flash_pins),
        .flash_io_in (flash_io_in)
    );

    spi_flash_model #(.qspi(tb_qspi)) flash (
        .pins  (flash_pins),
        .io_in (flash_io_in)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (flash_pins.csn) begin
            csn_high_cycles <= csn_high_cycles + 1;
        end
    end

    function automatic logic [7:0] content_byte(input logic [23:0] a);
        logic [31:0] mul;
        mul = a * 32'h9d + 32'h5b;
        return mul[7:0] ^ a[23:16];
    endfunction

    // little-endian word at a
    function automatic logic [31:0] expected_word(input logic [23:0] a);
        return {content_byte(a + 24'd3), content_byte(a + 24'd2),
                content_byte(a + 24'd1), content_byte(a)};
    endfunction

    task run_request(input logic [23:0] addr, input bit seq, input bit expect_hit);
        int          lat;
        int          csn_before;
        int          cmd_before;
        logic [31:0] exp;
        exp        = expected_word(addr);
        // a sequential word must keep the stream open since the last one
        csn_before = seq ? csn_mark : csn_high_cycles;
        cmd_before = cmd_mark;
        req_data.addr = addr;
        req = 1'b1;
        @(negedge clk);
        lat = 1;
        while (!ack && lat < ack_timeout) begin
            @(negedge clk);
            lat++;
        end
        if (!ack) begin
            $display("timeout waiting for ack at address %h", addr);
            hung = 1'b1;
        end else begin
            checks++;
            if (rsp.rdata !== exp) begin
                errors++;
                $display("[ERROR] rsp.rdata at %h: got %h, expected %h", addr, rsp.rdata, exp);
            end
            if (seq && csn_high_cycles != csn_before) begin
                errors++;
                $display("csn went high during a sequential read at address %h", addr);
            end
            if (seq && flash.cmd_count != cmd_before) begin
                errors++;
                $display("[ERROR] flash.cmd_count at %h: got %h, expected %h",
                         addr, flash.cmd_count, cmd_before);
            end
            if (!seq && csn_high_cycles == csn_before) begin
                errors++;
                $display("csn never went high before the restart at address %h", addr);
            end
            if (expect_hit && lat != 1) begin
                errors++;
                $display("[ERROR] ack latency at %h: got %h, expected %h", addr, lat, 1);
            end
            req = 1'b0;
            lat = 0;
            while (ack && lat < ack_timeout) begin
                @(negedge clk);
                lat++;
            end
            if (ack) begin
                $display("timeout waiting for ack to drop at address %h", addr);
                hung = 1'b1;
            end
            csn_mark = csn_high_cycles;
            cmd_mark = flash.cmd_count;
        end
    endtask

    initial begin
        logic [23:0] addr;
        logic [23:0] prev_addr;
        logic [31:0] rnd;
        int          pick;
        int          i;
        bit          seq;
        seed      = 54;
        errors    = 0;
        checks    = 0;
        hung      = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        rst_n     = 1'b0;
        prev_addr = 24'h0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle pins after reset
        repeat (8) begin
            @(negedge clk);
            if (flash_pins.csn !== 1'b1) begin
                errors++;
                $display("[ERROR] csn: got %h, expected %h", flash_pins.csn, 1'b1);
            end
            if (flash_pins.sclk !== 1'b1) begin
                errors++;
                $display("[ERROR] sclk: got %h, expected %h", flash_pins.sclk, 1'b1);
            end
            if (flash_pins.io_oe !== 4'h0) begin
                errors++;
                $display("[ERROR] io_oe: got %h, expected %h", flash_pins.io_oe, 4'h0);
            end
            if (ack !== 1'b0) begin
                errors++;
                $display("[ERROR] ack: got %h, expected %h", ack, 1'b0);
            end
        end

        // mixed stream, about 60 percent sequential
        i = 0;
        while (i < 80 && !hung) begin
            pick = $unsigned($random(seed)) % 100;
            rnd  = $random(seed);
            seq  = (i > 0) && (pick < 60);
            addr = seq ? prev_addr + 24'd4 : {rnd[23:2], 2'b00};
            if (i > 0 && addr == prev_addr + 24'd4) begin
                seq = 1'b1;
            end
            run_request(addr, seq, 1'b0);
            prev_addr = addr;
            i++;
        end

        // let the prefetch settle, then expect a one-cycle ack
        i = 0;
        while (i < 3 && !hung) begin
            rnd  = $random(seed);
            addr = {rnd[23:2], 2'b00};
            run_request(addr, addr == prev_addr + 24'd4, 1'b0);
            if (!hung) begin
                run_request(addr + 24'd4, 1'b1, 1'b0);
            end
            if (!hung) begin
                repeat (200) @(negedge clk);
                run_request(addr + 24'd8, 1'b1, 1'b1);
            end
            prev_addr = addr + 24'd8;
            i++;
        end

        if (tb_qspi && !hung) begin
            if (flash.quad_cmd_count != 1) begin
                errors++;
                $display("[ERROR] flash.quad_cmd_count: got %h, expected %h",
                         flash.quad_cmd_count, 1);
            end
            if (flash.mode_count != flash.addr_count) begin
                errors++;
                $display("[ERROR] flash.mode_count: got %h, expected %h",
                         flash.mode_count, flash.addr_count);
            end
        end

        $display("requests: %0d, errors: %0d, timeouts: %0d", checks, errors, hung);
        if (errors == 0 && !hung) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/flash_pkg.sv
design/flash_reader.sv
design/fetch_port.sv
design/flash_subsys.sv
sim/spi_flash_model.sv
sim/tb_flash_subsys.sv

// ==== Makefile ====
SRCS := $(shell cat vlog.f)

all: run

obj_quad/Vtb_flash_subsys: vlog.f $(SRCS)
	verilator --binary --timing -Mdir obj_quad -f vlog.f --top-module tb_flash_subsys -Gtb_qspi=1

obj_spi/Vtb_flash_subsys: vlog.f $(SRCS)
	verilator --binary --timing -Mdir obj_spi -f vlog.f --top-module tb_flash_subsys -Gtb_qspi=0

run: obj_quad/Vtb_flash_subsys obj_spi/Vtb_flash_subsys
	@for bin in $^; do \
		out=$$(./$$bin); \
		echo "$$out"; \
		echo "$$out" | grep -q "^Verification passed$$" || exit 1; \
	done

clean:
	rm -rf obj_quad obj_spi

.PHONY: all run clean
